/* rtl/zynq_shell_pkg.sv */
package zynq_shell_pkg;

   localparam int word_width = 32;

   typedef logic [word_width-1:0] word_t;
   typedef logic [word_width-1:0] addr_t;

   // host addresses arrive on the GP1 window with 0x8000_0000 already removed
   localparam addr_t host_split_addr  = 32'h2000_0000;
   localparam addr_t host_dram_offset = 32'h8000_0000;

   // the core sees its DRAM starting at 0x8000_0000
   localparam addr_t bp_dram_base     = 32'h8000_0000;
   localparam addr_t dram_limit_bytes = 32'h1000_0000;

   // one profiler bit per 8 MB region of the core address space
   localparam int num_regions   = 128;
   localparam int profile_words = num_regions / word_width;

   // host register map in byte addresses
   localparam addr_t csr_reset_addr      = 32'h0000_0000;
   localparam addr_t csr_dram_alloc_addr = 32'h0000_0004;
   localparam addr_t csr_dram_base_addr  = 32'h0000_0008;
   localparam addr_t csr_profile_addr    = 32'h0000_0010;

   typedef struct packed {
      logic  write;
      addr_t addr;
      word_t data;
   } csr_req_t;

   typedef enum logic {
      host_window_dram  = 1'b0,
      host_window_local = 1'b1
   } host_window_e;

   typedef struct packed {
      logic  write;
      addr_t addr;
   } host_req_t;

   // the region index sits in bits 29:23 of a core DRAM address
   typedef struct packed {
      logic [1:0]  top;
      logic [6:0]  region;
      logic [22:0] offset;
   } bp_dram_fields_t;

   typedef union packed {
      addr_t           raw;
      bp_dram_fields_t fields;
   } bp_dram_addr_u;

   typedef struct packed {
      logic          write;
      bp_dram_addr_u addr;
   } dram_req_t;

endpackage

/* rtl/shell_csr_bank.sv */
`timescale 1ns/1ps

module shell_csr_bank (
   input  logic                                     clk_i,
   input  logic                                     rst_i,

   input  logic                                     csr_req_v_i,
   input  zynq_shell_pkg::csr_req_t                 csr_req_i,

   input  logic [zynq_shell_pkg::num_regions-1:0]   profile_i,

   output logic                                     csr_rvalid_o,
   output zynq_shell_pkg::word_t                    csr_rdata_o,

   output logic                                     core_reset_n_o,
   output logic                                     dram_alloc_o,
   output zynq_shell_pkg::addr_t                    dram_base_o
);

   import zynq_shell_pkg::*;

   // registers written by the host
   word_t reset_r;
   word_t dram_alloc_r;
   addr_t dram_base_r;

   // read path
   word_t rdata_d;
   word_t rdata_r;
   logic  rvalid_r;

   logic  wr_v;
   logic  rd_v;

   assign wr_v = csr_req_v_i & csr_req_i.write;
   assign rd_v = csr_req_v_i & ~csr_req_i.write;

   // writes land on the edge that samples the strobe
   // so a read on the following cycle already sees them
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         reset_r      <= '0;
         dram_alloc_r <= '0;
         dram_base_r  <= '0;
      end else if (wr_v) begin
         case (csr_req_i.addr)
            csr_reset_addr: begin
               reset_r <= csr_req_i.data;
            end
            csr_dram_alloc_addr: begin
               dram_alloc_r <= csr_req_i.data;
            end
            csr_dram_base_addr: begin
               dram_base_r <= csr_req_i.data;
            end
            default: begin
               // profiler words and holes in the map are read only
            end
         endcase
      end
   end

   // read mux over the host registers and the profiler words
   always_comb begin
      rdata_d = '0;
      case (csr_req_i.addr)
         csr_reset_addr: begin
            rdata_d = reset_r;
         end
         csr_dram_alloc_addr: begin
            rdata_d = dram_alloc_r;
         end
         csr_dram_base_addr: begin
            rdata_d = dram_base_r;
         end
         default: begin
            for (int i = 0; i < profile_words; i++) begin
               if (csr_req_i.addr == addr_t'(csr_profile_addr + 4 * i)) begin
                  rdata_d = profile_i[i*word_width +: word_width];
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_r <= 1'b0;
      end else begin
         rvalid_r <= rd_v;
      end
   end

   // data only needs to be meaningful while rvalid is high
   always_ff @(posedge clk_i) begin
      if (rd_v) begin
         rdata_r <= rdata_d;
      end
   end

   assign csr_rvalid_o = rvalid_r;
   assign csr_rdata_o  = rdata_r;

   // the core is held in reset until the host writes a nonzero value
   assign core_reset_n_o = (reset_r != '0);
   assign dram_alloc_o   = (dram_alloc_r != '0);
   assign dram_base_o    = dram_base_r;

endmodule

/* rtl/host_addr_xlate.sv */
`timescale 1ns/1ps

module host_addr_xlate (
   input  logic                          clk_i,
   input  logic                          rst_i,

   input  logic                          host_req_v_i,
   input  zynq_shell_pkg::host_req_t     host_req_i,

   output logic                          bp_req_v_o,
   output zynq_shell_pkg::host_req_t     bp_req_o,
   output zynq_shell_pkg::host_window_e  bp_window_o
);

   import zynq_shell_pkg::*;

   logic         below_split;
   host_req_t    req_d;
   host_window_e window_d;

   logic         req_v_r;
   host_req_t    req_r;
   host_window_e window_r;

   // the lower part of GP1 maps onto core DRAM at 0x8000_0000
   // and the upper part maps onto the core's local space from zero
   assign below_split = (host_req_i.addr < host_split_addr);

   always_comb begin
      req_d.write = host_req_i.write;
      if (below_split) begin
         req_d.addr = host_req_i.addr + host_dram_offset;
         window_d   = host_window_dram;
      end else begin
         req_d.addr = host_req_i.addr - host_split_addr;
         window_d   = host_window_local;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         req_v_r <= 1'b0;
      end else begin
         req_v_r <= host_req_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_req_v_i) begin
         req_r    <= req_d;
         window_r <= window_d;
      end
   end

   assign bp_req_v_o  = req_v_r;
   assign bp_req_o    = req_r;
   assign bp_window_o = window_r;

endmodule

/* rtl/dram_addr_xlate.sv */
`timescale 1ns/1ps

module dram_addr_xlate (
   input  logic                       clk_i,
   input  logic                       rst_i,

   input  logic                       dram_req_v_i,
   input  zynq_shell_pkg::dram_req_t  dram_req_i,

   // physical base of the DRAM block the host allocated for the core
   input  zynq_shell_pkg::addr_t      dram_base_i,

   output logic                       ps_dram_req_v_o,
   output zynq_shell_pkg::host_req_t  ps_dram_req_o,
   output logic                       dram_oob_o
);

   import zynq_shell_pkg::*;

   addr_t     offset;
   host_req_t req_d;
   logic      oob_d;

   logic      req_v_r;
   host_req_t req_r;
   logic      oob_r;

   // flipping the top bit removes the core DRAM base in one step
   assign offset = dram_req_i.addr.raw ^ bp_dram_base;

   always_comb begin
      req_d.write = dram_req_i.write;
      req_d.addr  = offset + dram_base_i;
   end

   // anything past the allocated block would land in memory owned by the PS
   assign oob_d = (offset >= dram_limit_bytes);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         req_v_r <= 1'b0;
         oob_r   <= 1'b0;
      end else begin
         req_v_r <= dram_req_v_i;
         oob_r   <= dram_req_v_i & oob_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (dram_req_v_i) begin
         req_r <= req_d;
      end
   end

   assign ps_dram_req_v_o = req_v_r;
   assign ps_dram_req_o   = req_r;
   assign dram_oob_o      = oob_r;

endmodule

/* rtl/mem_region_profiler.sv */
`timescale 1ns/1ps

module mem_region_profiler (
   input  logic                                   clk_i,
   input  logic                                   bp_reset_i,

   input  logic                                   dram_req_v_i,
   input  zynq_shell_pkg::dram_req_t              dram_req_i,

   output logic [zynq_shell_pkg::num_regions-1:0] profile_o
);

   import zynq_shell_pkg::*;

   logic [num_regions-1:0] hit_mask;
   logic [num_regions-1:0] profile_r;

   // one-hot mask of the 8 MB region this request touches
   always_comb begin
      hit_mask = '0;
      if (dram_req_v_i) begin
         hit_mask[dram_req_i.addr.fields.region] = 1'b1;
      end
   end

   // bits are sticky until the core goes back into reset
   always_ff @(posedge clk_i) begin
      if (bp_reset_i) begin
         profile_r <= '0;
      end else begin
         profile_r <= profile_r | hit_mask;
      end
   end

   assign profile_o = profile_r;

endmodule

/* rtl/zynq_shell_top.sv */
`timescale 1ns/1ps

module zynq_shell_top (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // host register port
   input  logic                          csr_req_v_i,
   input  zynq_shell_pkg::csr_req_t      csr_req_i,
   output logic                          csr_rvalid_o,
   output zynq_shell_pkg::word_t         csr_rdata_o,

   // host accesses through the GP1 window into the core
   input  logic                          host_req_v_i,
   input  zynq_shell_pkg::host_req_t     host_req_i,
   output logic                          bp_req_v_o,
   output zynq_shell_pkg::host_req_t     bp_req_o,
   output zynq_shell_pkg::host_window_e  bp_window_o,

   // core accesses out to PS DRAM
   input  logic                          dram_req_v_i,
   input  zynq_shell_pkg::dram_req_t     dram_req_i,
   output logic                          ps_dram_req_v_o,
   output zynq_shell_pkg::host_req_t     ps_dram_req_o,
   output logic                          dram_oob_o,

   output logic                          dram_alloc_o,
   output logic                          bp_reset_o
);

   import zynq_shell_pkg::*;

   logic                   core_reset_n;
   logic                   bp_reset;
   addr_t                  dram_base;
   logic [num_regions-1:0] profile;

   // the host can restart the core by toggling the reset register
   // without a new bitstream or a shell reset
   assign bp_reset   = rst_i | ~core_reset_n;
   assign bp_reset_o = bp_reset;

   shell_csr_bank u_csr_bank (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .csr_req_v_i    (csr_req_v_i),
      .csr_req_i      (csr_req_i),
      .profile_i      (profile),
      .csr_rvalid_o   (csr_rvalid_o),
      .csr_rdata_o    (csr_rdata_o),
      .core_reset_n_o (core_reset_n),
      .dram_alloc_o   (dram_alloc_o),
      .dram_base_o    (dram_base)
   );

   host_addr_xlate u_host_xlate (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .host_req_v_i (host_req_v_i),
      .host_req_i   (host_req_i),
      .bp_req_v_o   (bp_req_v_o),
      .bp_req_o     (bp_req_o),
      .bp_window_o  (bp_window_o)
   );

   dram_addr_xlate u_dram_xlate (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .dram_req_v_i    (dram_req_v_i),
      .dram_req_i      (dram_req_i),
      .dram_base_i     (dram_base),
      .ps_dram_req_v_o (ps_dram_req_v_o),
      .ps_dram_req_o   (ps_dram_req_o),
      .dram_oob_o      (dram_oob_o)
   );

   // the profiler follows the core reset so the host can clear it
   mem_region_profiler u_profiler (
      .clk_i        (clk_i),
      .bp_reset_i   (bp_reset),
      .dram_req_v_i (dram_req_v_i),
      .dram_req_i   (dram_req_i),
      .profile_o    (profile)
   );

endmodule

/* dv/zynq_shell_assertions.sv */
`timescale 1ns/1ps

module zynq_shell_assertions (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic                     csr_req_v_i,
   input zynq_shell_pkg::csr_req_t csr_req_i,
   input logic                     csr_rvalid_o,
   input logic                     host_req_v_i,
   input logic                     bp_req_v_o,
   input logic                     dram_req_v_i,
   input logic                     ps_dram_req_v_o,
   input logic                     dram_oob_o
);

   logic rd_req;

   assign rd_req = csr_req_v_i & ~csr_req_i.write;

   // every output strobe answers exactly one input strobe from the cycle before
   host_strobe_a: assert property (@(posedge clk_i) disable iff (rst_i)
      bp_req_v_o == $past(host_req_v_i))
      else $error("bp_req_v_o does not follow host_req_v_i by one cycle");

   dram_strobe_a: assert property (@(posedge clk_i) disable iff (rst_i)
      ps_dram_req_v_o == $past(dram_req_v_i))
      else $error("ps_dram_req_v_o does not follow dram_req_v_i by one cycle");

   read_strobe_a: assert property (@(posedge clk_i) disable iff (rst_i)
      csr_rvalid_o == $past(rd_req))
      else $error("csr_rvalid_o does not follow a register read by one cycle");

   // outputs are registered, so a reset seen on one edge clears them by the next
   reset_quiet_a: assert property (@(posedge clk_i)
      rst_i |=> !(csr_rvalid_o | bp_req_v_o | ps_dram_req_v_o | dram_oob_o))
      else $error("a strobe is high during reset");

endmodule

/* dv/zynq_shell_tb.sv */
`timescale 1ns/1ps

module zynq_shell_tb;

   import zynq_shell_pkg::*;

   // one operation per request cycle summed over the five tests
   localparam int num_ops       = 80;
   localparam int cycles_per_op = 20;

   logic         clk_i;
   logic         rst_i;
   logic         csr_req_v_i;
   csr_req_t     csr_req_i;
   logic         csr_rvalid_o;
   word_t        csr_rdata_o;
   logic         host_req_v_i;
   host_req_t    host_req_i;
   logic         bp_req_v_o;
   host_req_t    bp_req_o;
   host_window_e bp_window_o;
   logic         dram_req_v_i;
   dram_req_t    dram_req_i;
   logic         ps_dram_req_v_o;
   host_req_t    ps_dram_req_o;
   logic         dram_oob_o;
   logic         dram_alloc_o;
   logic         bp_reset_o;

   int errors = 0;
   int checks = 0;
   logic [31:0] lcg_state;

   zynq_shell_top DUT (.*);

   bind zynq_shell_top zynq_shell_assertions u_assertions (.*);

   initial begin
      clk_i = 1'b0;
      forever begin
         #5 clk_i = ~clk_i;
      end
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   // the request tasks start and end on a falling edge
   task automatic write_csr(input addr_t addr, input word_t data);
      csr_req_v_i = 1'b1;
      csr_req_i   = '{write: 1'b1, addr: addr, data: data};
      @(negedge clk_i);
      csr_req_v_i = 1'b0;
   endtask

   task automatic expect_csr(input addr_t addr, input word_t expected);
      csr_req_v_i = 1'b1;
      csr_req_i   = '{write: 1'b0, addr: addr, data: '0};
      @(negedge clk_i);
      csr_req_v_i = 1'b0;
      check_value("csr_rvalid_o", 32'(csr_rvalid_o), 32'd1);
      check_value($sformatf("csr_rdata_o (addr %h)", addr), csr_rdata_o, expected);
   endtask

   task automatic reset_defaults();
      check_value("bp_reset_o", 32'(bp_reset_o), 32'd1);
      check_value("dram_alloc_o", 32'(dram_alloc_o), 32'd0);
      check_value("dram_oob_o", 32'(dram_oob_o), 32'd0);
      for (int i = 0; i < 7; i++) begin
         expect_csr(i < 3 ? addr_t'(4 * i) : addr_t'(4 * i + 4), 32'd0);
      end
   endtask

   task automatic register_readback();
      write_csr(csr_reset_addr, 32'd1);
      check_value("bp_reset_o", 32'(bp_reset_o), 32'd0);
      expect_csr(csr_reset_addr, 32'd1);
      write_csr(csr_dram_alloc_addr, 32'd1);
      check_value("dram_alloc_o", 32'(dram_alloc_o), 32'd1);
      expect_csr(csr_dram_alloc_addr, 32'd1);
      write_csr(csr_dram_base_addr, 32'h1234_5000);
      expect_csr(csr_dram_base_addr, 32'h1234_5000);
      write_csr(csr_dram_alloc_addr, 32'd0);
      check_value("dram_alloc_o", 32'(dram_alloc_o), 32'd0);
      // profiler words and holes in the map ignore writes
      write_csr(csr_profile_addr + 32'd4, 32'hffff_ffff);
      expect_csr(csr_profile_addr + 32'd4, 32'd0);
      write_csr(32'h0000_0020, 32'hdead_beef);
      expect_csr(32'h0000_0020, 32'd0);
   endtask

   task automatic host_translation();
      logic [31:0]  rnd;
      addr_t        addr;
      addr_t        exp_addr;
      host_window_e exp_win;
      for (int i = 0; i < 20; i++) begin
         rnd  = next_rand();
         addr = (i % 2 == 0) ? (rnd & 32'h1fff_ffff) : (rnd | 32'h2000_0000);
         if (i == 1) begin
            addr = 32'h2000_0000;
         end
         exp_win  = (addr < 32'h2000_0000) ? host_window_dram : host_window_local;
         exp_addr = (addr < 32'h2000_0000) ? addr + 32'h8000_0000 : addr - 32'h2000_0000;
         // strobes stay high from one request to the next
         host_req_v_i = 1'b1;
         host_req_i   = '{write: rnd[16], addr: addr};
         @(negedge clk_i);
         check_value("bp_req_v_o", 32'(bp_req_v_o), 32'd1);
         check_value("bp_req_o.addr", bp_req_o.addr, exp_addr);
         check_value("bp_req_o.write", 32'(bp_req_o.write), 32'(rnd[16]));
         check_value("bp_window_o", 32'(bp_window_o), 32'(exp_win));
      end
      host_req_v_i = 1'b0;
   endtask

   task automatic dram_translation();
      logic [95:0] bases;
      logic [31:0] rnd;
      addr_t       base;
      addr_t       addr;
      addr_t       offset;
      bases = {32'h3ab0_0000, 32'h1000_0000, 32'h0000_0000};
      for (int b = 0; b < 3; b++) begin
         base = 32'(bases >> (32 * b));
         write_csr(csr_dram_base_addr, base);
         for (int k = 0; k < 6; k++) begin
            rnd = next_rand();
            case (k)
               0: addr = 32'h8fff_ffff;
               1: addr = 32'h9000_0000;
               4: addr = 32'h9000_0000 + (rnd & 32'h0fff_ffff);
               5: addr = rnd;
               default: addr = 32'h8000_0000 + (rnd & 32'h0fff_ffff);
            endcase
            offset = addr ^ 32'h8000_0000;
            dram_req_v_i   = 1'b1;
            dram_req_i.write    = rnd[3];
            dram_req_i.addr.raw = addr;
            @(negedge clk_i);
            check_value("ps_dram_req_v_o", 32'(ps_dram_req_v_o), 32'd1);
            check_value("ps_dram_req_o.addr", ps_dram_req_o.addr, offset + base);
            check_value("ps_dram_req_o.write", 32'(ps_dram_req_o.write), 32'(rnd[3]));
            check_value("dram_oob_o", 32'(dram_oob_o), 32'(offset >= 32'h1000_0000));
         end
         dram_req_v_i = 1'b0;
      end
   endtask

   task automatic region_profiling();
      logic [62:0]  regions;
      logic [127:0] expected;
      logic [31:0]  rnd;
      logic [6:0]   region;
      // region 5 appears twice to show that bits are sticky
      // the last region is new so the read that follows it must already see its bit
      regions  = {7'd127, 7'd100, 7'd64, 7'd63, 7'd5, 7'd32, 7'd31, 7'd5, 7'd0};
      expected = '0;
      write_csr(csr_reset_addr, 32'd0);
      check_value("bp_reset_o", 32'(bp_reset_o), 32'd1);
      write_csr(csr_reset_addr, 32'd1);
      for (int i = 0; i < 9; i++) begin
         rnd    = next_rand();
         region = 7'(regions >> (7 * i));
         dram_req_v_i     = 1'b1;
         dram_req_i.write = rnd[0];
         dram_req_i.addr.raw = {2'b10, region, rnd[22:0]};
         expected = expected | (128'd1 << region);
         @(negedge clk_i);
      end
      dram_req_v_i = 1'b0;
      for (int w = 3; w >= 0; w--) begin
         expect_csr(csr_profile_addr + addr_t'(4 * w), 32'(expected >> (32 * w)));
      end
      write_csr(csr_reset_addr, 32'd0);
      write_csr(csr_reset_addr, 32'd1);
      for (int w = 0; w < 4; w++) begin
         expect_csr(csr_profile_addr + addr_t'(4 * w), 32'd0);
      end
   endtask

   initial begin
      repeat (num_ops * cycles_per_op + 4) @(posedge clk_i);
      $display("timeout: the tests did not finish within %0d cycles",
               num_ops * cycles_per_op + 4);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      lcg_state    = 32'hde1a;
      rst_i        = 1'b1;
      csr_req_v_i  = 1'b0;
      csr_req_i    = '0;
      host_req_v_i = 1'b0;
      host_req_i   = '0;
      dram_req_v_i = 1'b0;
      dram_req_i   = '0;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      reset_defaults();
      register_readback();
      host_translation();
      dram_translation();
      region_profiling();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* zynq_shell.f */
rtl/zynq_shell_pkg.sv
rtl/shell_csr_bank.sv
rtl/host_addr_xlate.sv
rtl/dram_addr_xlate.sv
rtl/mem_region_profiler.sv
rtl/zynq_shell_top.sv
dv/zynq_shell_assertions.sv
dv/zynq_shell_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the Verilator model of the testbench and runs it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f zynq_shell.f \
   --top-module zynq_shell_tb \
   -o zynq_shell_sim

# an assertion failure stops the model early, the search below then finds no pass line
output="$(./obj_dir/zynq_shell_sim 2>&1 || true)"
echo "${output}"

if grep -q "SIMULATION PASSED" <<< "${output}"; then
   exit 0
else
   exit 1
fi
